//--- bench/axi_mem_model.sv
`default_nettype none

module axi_mem_model (
  input  logic           clock,
  input  logic           reset,
  input  logic           arvalid,
  input  bus_pkg::ar_t   ar,
  output logic           arready,
  output logic           rvalid,
  output bus_pkg::r_t    r,
  input  logic           rready,
  input  logic           awvalid,
  input  bus_pkg::aw_t   aw,
  output logic           awready,
  input  logic           wvalid,
  input  bus_pkg::w_t    w,
  output logic           wready,
  output logic           bvalid,
  output bus_pkg::resp_t bresp,
  input  logic           bready
);

  timeunit 1ns;
  timeprecision 1ns;

  bus_pkg::data_t mem [bus_pkg::addr_t];  // sparse, keyed by word address

  logic           ar_rdy = 1'b0;
  logic           r_vld = 1'b0;
  bus_pkg::r_t    r_q = '0;
  logic           w_rdy = 1'b0;
  logic           b_vld = 1'b0;
  logic           rd_pend = 1'b0;
  bus_pkg::addr_t rd_addr = '0;
  int             rd_wait = 0;
  logic [31:0]    rng = 32'd87;

  assign arready = ar_rdy;
  assign rvalid  = r_vld;
  assign r       = r_q;
  assign awready = w_rdy;
  assign wready  = w_rdy;
  assign bvalid  = b_vld;
  assign bresp   = bus_pkg::resp_okay;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic bus_pkg::data_t word_at(input bus_pkg::addr_t a);
    bus_pkg::addr_t key;
    key = {a[31:2], 2'b00};
    if (mem.exists(key)) return mem[key];
    return key ^ 32'h5a5a_a5a5;  // unwritten words
  endfunction

  always @(posedge clock) begin
    bus_pkg::data_t old;
    if (reset) begin
      ar_rdy  <= 1'b0;
      r_vld   <= 1'b0;
      w_rdy   <= 1'b0;
      b_vld   <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      rng <= xorshift(rng);
      if (r_vld && rready) r_vld <= 1'b0;
      if (arvalid && ar_rdy) begin
        ar_rdy  <= 1'b0;
        rd_pend <= 1'b1;
        rd_addr <= ar.addr;
        rd_wait <= int'(rng[1:0]);
      end else if (!rd_pend && !r_vld) begin
        ar_rdy <= rng[4];
      end
      if (rd_pend) begin
        if (rd_wait == 0) begin
          rd_pend    <= 1'b0;
          r_vld      <= 1'b1;
          r_q.data   <= word_at(rd_addr);
          r_q.resp   <= bus_pkg::resp_okay;
        end else begin
          rd_wait <= rd_wait - 1;
        end
      end
      // aw and w are taken together
      if (b_vld && bready) b_vld <= 1'b0;
      if (w_rdy && awvalid && wvalid) begin
        old = word_at(aw.addr);
        for (int i = 0; i < 4; i++) begin
          if (w.strb[i]) old[8*i +: 8] = w.data[8*i +: 8];
        end
        mem[{aw.addr[31:2], 2'b00}] = old;
        w_rdy <= 1'b0;
        b_vld <= 1'b1;
      end else if (awvalid && wvalid && !b_vld) begin
        w_rdy <= rng[7];
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem;

  timeunit 1ns;
  timeprecision 1ns;

  localparam bus_pkg::addr_t CLINT_BASE = 32'h0200_0000;
  localparam int TIMER_DIV = 4;
  localparam int N_FETCH = 20;
  localparam int N_DATA = 20;
  localparam int N_WRITE = 16;
  localparam int N_MTIME = 6;
  localparam int N_PAIR = 8;
  localparam int N_TOTAL = N_FETCH + N_DATA + 2 * N_WRITE + N_MTIME + 2 * N_PAIR;

  logic clock;
  logic reset;
  logic f_arvalid, f_arready, f_rvalid, f_rready;
  logic d_arvalid, d_arready, d_rvalid, d_rready;
  logic d_awvalid, d_awready, d_wvalid, d_wready, d_bvalid, d_bready;
  logic m_arvalid, m_arready, m_rvalid, m_rready;
  logic m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  bus_pkg::addr_t f_araddr;
  bus_pkg::ar_t   d_ar, m_ar;
  bus_pkg::r_t    f_r, d_r, m_r;
  bus_pkg::aw_t   d_aw, m_aw;
  bus_pkg::w_t    d_w, m_w;
  bus_pkg::resp_t d_bresp, m_bresp;

  bus_pkg::data_t shadow [bus_pkg::addr_t];
  bus_pkg::data_t exp_f [$];
  bus_pkg::data_t exp_d [$];
  logic [31:0]    rng = 32'd87;
  int             cyc = 0;
  logic           f_hold = 1'b0;
  logic           d_hold = 1'b0;
  bus_pkg::data_t f_hold_data, d_hold_data;
  int             f_resp_cyc, d_resp_cyc;

  clock_gen clk0 (.clock(clock), .reset(reset));

  mem_subsystem #(.CLINT_BASE(CLINT_BASE), .TIMER_DIV(TIMER_DIV)) dut0 (.*);

  axi_mem_model mem0 (
    .clock(clock), .reset(reset),
    .arvalid(m_arvalid), .ar(m_ar), .arready(m_arready),
    .rvalid(m_rvalid), .r(m_r), .rready(m_rready),
    .awvalid(m_awvalid), .aw(m_aw), .awready(m_awready),
    .wvalid(m_wvalid), .w(m_w), .wready(m_wready),
    .bvalid(m_bvalid), .bresp(m_bresp), .bready(m_bready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // expected memory contents
  function automatic bus_pkg::data_t mem_ref(input bus_pkg::addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return a ^ 32'h5a5a_a5a5;
  endfunction

  function automatic bus_pkg::data_t data_ref(input bus_pkg::addr_t a);
    if (a == CLINT_BASE + 32'h48) return bus_pkg::data_t'(cyc / TIMER_DIV);
    if (a == CLINT_BASE + 32'h4c) return '0;
    return mem_ref(a);
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  always @(posedge clock) if (!reset) cyc <= cyc + 1;  // edges since reset release

  always @(negedge clock) begin
    if (!reset) begin
      if (f_hold) begin
        check("fetch rvalid held", f_rvalid, 1);
        check("fetch data held", f_r.data, f_hold_data);
      end
      if (d_hold) begin
        check("data rvalid held", d_rvalid, 1);
        check("data data held", d_r.data, d_hold_data);
      end
      f_hold = f_rvalid && !f_rready;
      f_hold_data = f_r.data;
      d_hold = d_rvalid && !d_rready;
      d_hold_data = d_r.data;
      if (m_arvalid && m_arready) check("external read size", m_ar.size, bus_pkg::size_word);
      if (m_awvalid && m_awready) check("external write size", m_aw.size, bus_pkg::size_word);
      if (f_arvalid && f_arready) exp_f.push_back(mem_ref(f_araddr));
      if (d_arvalid && d_arready) exp_d.push_back(data_ref(d_ar.addr));
      if (f_rvalid && f_rready) begin
        check("fetch response expected", exp_f.size() != 0, 1);
        check("fetch data", f_r.data, exp_f.pop_front());
        check("fetch resp", f_r.resp, bus_pkg::resp_okay);
        f_resp_cyc = cyc;
      end
      if (d_rvalid && d_rready) begin
        check("data response expected", exp_d.size() != 0, 1);
        check("data read", d_r.data, exp_d.pop_front());
        check("data resp", d_r.resp, bus_pkg::resp_okay);
        d_resp_cyc = cyc;
      end
    end
  end

  task automatic fetch_read(input bus_pkg::addr_t a);
    logic done;
    @(posedge clock);
    f_arvalid <= 1'b1;
    f_araddr  <= a;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = f_arready;
      @(posedge clock);
    end
    f_arvalid <= 1'b0;
    done = 1'b0;
    while (!done) begin
      f_rready <= next_rand() > 32'h6000_0000;  // random back-pressure
      @(negedge clock);
      done = f_rvalid && f_rready;
      @(posedge clock);
    end
    f_rready <= 1'b0;
  endtask

  task automatic data_read(input bus_pkg::addr_t a);
    logic done;
    @(posedge clock);
    d_arvalid <= 1'b1;
    d_ar      <= '{addr: a, size: bus_pkg::size_word};
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = d_arready;
      @(posedge clock);
    end
    d_arvalid <= 1'b0;
    done = 1'b0;
    while (!done) begin
      d_rready <= next_rand() > 32'h6000_0000;
      @(negedge clock);
      done = d_rvalid && d_rready;
      @(posedge clock);
    end
    d_rready <= 1'b0;
  endtask

  task automatic data_write(input bus_pkg::addr_t a, input bus_pkg::data_t v,
                            input bus_pkg::strb_t s);
    logic done;
    bus_pkg::data_t old;
    old = mem_ref(a);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) old[8*i +: 8] = v[8*i +: 8];
    end
    shadow[a] = old;
    @(posedge clock);
    d_awvalid <= 1'b1;
    d_wvalid  <= 1'b1;
    d_aw      <= '{addr: a, size: bus_pkg::size_word};
    d_w       <= '{data: v, strb: s};
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = d_awready && d_wready;
      @(posedge clock);
    end
    d_awvalid <= 1'b0;
    d_wvalid  <= 1'b0;
    d_bready  <= 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = d_bvalid;
      if (done) check("write resp", d_bresp, bus_pkg::resp_okay);
      @(posedge clock);
    end
    d_bready <= 1'b0;
  endtask

  initial begin
    #((N_TOTAL * 50 + 200) * 100);
    $display("ERROR: the run timed out before all transactions finished");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog");
  end

  initial begin
    bus_pkg::addr_t a;
    bus_pkg::addr_t b;
    f_arvalid = 1'b0;
    f_araddr  = '0;
    f_rready  = 1'b0;
    d_arvalid = 1'b0;
    d_ar      = '0;
    d_rready  = 1'b0;
    d_awvalid = 1'b0;
    d_aw      = '0;
    d_wvalid  = 1'b0;
    d_w       = '0;
    d_bready  = 1'b0;
    @(negedge clock);
    while (reset) @(negedge clock);
    for (int i = 0; i < N_FETCH; i++) fetch_read(next_rand() & 32'h0000_fffc);
    for (int i = 0; i < N_DATA; i++) data_read(32'h1000_0000 | (next_rand() & 32'h3fc));
    for (int i = 0; i < N_WRITE; i++) begin
      a = 32'h1000_0000 | (next_rand() & 32'h3fc);
      data_write(a, next_rand(), bus_pkg::strb_t'(next_rand()));
      data_read(a);
    end
    for (int i = 0; i < N_MTIME; i++) begin
      data_read(CLINT_BASE + ((i % 2 == 0) ? 32'h48 : 32'h4c));
      repeat (next_rand() & 7) @(posedge clock);
    end
    for (int i = 0; i < N_PAIR; i++) begin
      a = next_rand() & 32'h0000_fffc;
      b = 32'h1000_0000 | (next_rand() & 32'h3fc);
      fork
        fetch_read(a);
        data_read(b);
      join
      check("fetch answered first", f_resp_cyc < d_resp_cyc, 1);
    end
    repeat (2) @(posedge clock);
    if (exp_f.size() == 0 && exp_d.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("ERROR: some read requests never got a response");
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing responses");
    end
  end

endmodule

`default_nettype wire

//--- clint/clint.sv
`default_nettype none

module clint #(
  parameter bus_pkg::addr_t CLINT_BASE = 32'h0200_0000,
  parameter int TIMER_DIV = 4
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           arvalid,
  input  bus_pkg::addr_t araddr,
  output logic           arready,
  output logic           rvalid,
  output bus_pkg::r_t    r,
  input  logic           rready
);

  localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TIMER_DIV - 1);

  logic [DIV_W-1:0] prescale;
  logic [63:0]      mtime;
  logic             tick;
  logic             hit_lo;
  logic             hit_hi;

  assign tick = (prescale == DIV_LAST);

  always_ff @(posedge clock) begin
    if (reset) begin
      prescale <= '0;
      mtime    <= '0;
    end else if (tick) begin
      prescale <= '0;
      mtime    <= mtime + 64'd1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  assign hit_lo = (araddr == CLINT_BASE + bus_pkg::mtime_lo_off);
  assign hit_hi = (araddr == CLINT_BASE + bus_pkg::mtime_hi_off);

  assign arready = !rvalid;  // one response at a time

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // response payload, sampled from this cycle's counter
  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      if (hit_hi) begin
        r.data <= mtime[63:32];
      end else if (hit_lo) begin
        r.data <= mtime[31:0];
      end else begin
        r.data <= '0;
      end
      r.resp <= bus_pkg::resp_okay;
    end
  end

endmodule

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // widths with a meaning on the bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  resp_t;

  // read address channel payload
  typedef struct packed {
    addr_t addr;
    size_t size;
  } ar_t;

  // write address channel payload
  typedef struct packed {
    addr_t addr;
    size_t size;
  } aw_t;

  // write data channel payload
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_t;

  // read response channel payload
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_t;

  localparam resp_t resp_okay = 2'b00;
  localparam size_t size_word = 3'b010;  // 4 bytes

  // mtime word offsets inside the clint window
  localparam addr_t mtime_lo_off = 32'h0000_0048;
  localparam addr_t mtime_hi_off = 32'h0000_004c;

endpackage

`default_nettype wire

//--- project.f
common/bus_pkg.sv
clint/clint.sv
rtl/axi_arbiter.sv
rtl/mem_subsystem.sv
bench/clock_gen.sv
bench/axi_mem_model.sv
bench/tb_mem_subsystem.sv

//--- rtl/axi_arbiter.sv
`default_nettype none

module axi_arbiter #(
  parameter bus_pkg::addr_t CLINT_BASE = 32'h0200_0000,
  parameter int TIMER_DIV = 4
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           f_arvalid,
  input  bus_pkg::addr_t f_araddr,
  output logic           f_arready,
  output logic           f_rvalid,
  output bus_pkg::r_t    f_r,
  input  logic           f_rready,
  input  logic           d_arvalid,
  input  bus_pkg::ar_t   d_ar,
  output logic           d_arready,
  output logic           d_rvalid,
  output bus_pkg::r_t    d_r,
  input  logic           d_rready,
  input  logic           d_awvalid,
  input  bus_pkg::aw_t   d_aw,
  output logic           d_awready,
  input  logic           d_wvalid,
  input  bus_pkg::w_t    d_w,
  output logic           d_wready,
  output logic           d_bvalid,
  output bus_pkg::resp_t d_bresp,
  input  logic           d_bready,
  output logic           m_arvalid,
  output bus_pkg::ar_t   m_ar,
  input  logic           m_arready,
  input  logic           m_rvalid,
  input  bus_pkg::r_t    m_r,
  output logic           m_rready,
  output logic           m_awvalid,
  output bus_pkg::aw_t   m_aw,
  input  logic           m_awready,
  output logic           m_wvalid,
  output bus_pkg::w_t    m_w,
  input  logic           m_wready,
  input  logic           m_bvalid,
  input  bus_pkg::resp_t m_bresp,
  output logic           m_bready
);

  typedef enum logic [1:0] {
    own_idle,
    own_fetch,
    own_data
  } owner_e;

  owner_e owner;

  logic d_qual;      // data read address decoded
  logic d_is_clint;  // decoded address hits mtime
  logic d_busy;      // data read accepted, response not yet taken
  logic addr_is_mtime;
  logic d_ext_req;
  logic ext_idle;
  logic d_ar_hs;
  logic d_r_hs;

  bus_pkg::ar_t f_ar;

  logic        c_arvalid;
  logic        c_arready;
  logic        c_rvalid;
  bus_pkg::r_t c_r;

  assign addr_is_mtime = (d_ar.addr == CLINT_BASE + bus_pkg::mtime_lo_off) ||
                         (d_ar.addr == CLINT_BASE + bus_pkg::mtime_hi_off);

  // fetch reads are always full words
  assign f_ar.addr = f_araddr;
  assign f_ar.size = bus_pkg::size_word;

  assign ext_idle  = (owner == own_idle);
  assign d_ext_req = d_arvalid && d_qual && !d_is_clint;

  // fetch has fixed priority over data
  assign m_arvalid = ext_idle && (f_arvalid || d_ext_req);
  assign m_ar      = f_arvalid ? f_ar : d_ar;
  assign f_arready = ext_idle && m_arready;

  assign c_arvalid = d_arvalid && d_qual && d_is_clint;
  assign d_arready = d_qual && (d_is_clint ? c_arready
                                           : (ext_idle && !f_arvalid && m_arready));

  assign d_ar_hs = d_arvalid && d_arready;
  assign d_r_hs  = d_rvalid && d_rready;

  // responses go back to whoever owns the external read
  assign m_rready = (owner == own_fetch) ? f_rready :
                    (owner == own_data)  ? d_rready : 1'b0;
  assign f_rvalid = (owner == own_fetch) && m_rvalid;
  assign f_r      = m_r;
  assign d_rvalid = d_is_clint ? c_rvalid : ((owner == own_data) && m_rvalid);
  assign d_r      = d_is_clint ? c_r : m_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      owner <= own_idle;
    end else if (m_arvalid && m_arready) begin
      owner <= f_arvalid ? own_fetch : own_data;
    end else if (m_rvalid && m_rready) begin
      owner <= own_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      d_qual     <= 1'b0;
      d_is_clint <= 1'b0;
      d_busy     <= 1'b0;
    end else begin
      if (d_ar_hs) begin
        d_qual <= 1'b0;
        d_busy <= 1'b1;
      end else if (d_arvalid && !d_qual && !d_busy) begin
        d_qual     <= 1'b1;
        d_is_clint <= addr_is_mtime;  // held until the response is taken
      end
      if (d_r_hs) d_busy <= 1'b0;
    end
  end

  clint #(
    .CLINT_BASE(CLINT_BASE),
    .TIMER_DIV (TIMER_DIV)
  ) clint0 (
    .clock  (clock),
    .reset  (reset),
    .arvalid(c_arvalid),
    .araddr (d_ar.addr),
    .arready(c_arready),
    .rvalid (c_rvalid),
    .r      (c_r),
    .rready (d_rready)
  );

  // write channels pass straight through
  assign m_awvalid = d_awvalid;
  assign m_aw      = d_aw;
  assign d_awready = m_awready;
  assign m_wvalid  = d_wvalid;
  assign m_w       = d_w;
  assign d_wready  = m_wready;
  assign d_bvalid  = m_bvalid;
  assign d_bresp   = m_bresp;
  assign m_bready  = d_bready;

endmodule

`default_nettype wire

//--- rtl/mem_subsystem.sv
`default_nettype none

module mem_subsystem #(
  parameter bus_pkg::addr_t CLINT_BASE = 32'h0200_0000,
  parameter int TIMER_DIV = 4
) (
  input  logic           clock,
  input  logic           reset,
  // instruction fetch
  input  logic           f_arvalid,
  input  bus_pkg::addr_t f_araddr,
  output logic           f_arready,
  output logic           f_rvalid,
  output bus_pkg::r_t    f_r,
  input  logic           f_rready,
  // data port
  input  logic           d_arvalid,
  input  bus_pkg::ar_t   d_ar,
  output logic           d_arready,
  output logic           d_rvalid,
  output bus_pkg::r_t    d_r,
  input  logic           d_rready,
  input  logic           d_awvalid,
  input  bus_pkg::aw_t   d_aw,
  output logic           d_awready,
  input  logic           d_wvalid,
  input  bus_pkg::w_t    d_w,
  output logic           d_wready,
  output logic           d_bvalid,
  output bus_pkg::resp_t d_bresp,
  input  logic           d_bready,
  // external master
  output logic           m_arvalid,
  output bus_pkg::ar_t   m_ar,
  input  logic           m_arready,
  input  logic           m_rvalid,
  input  bus_pkg::r_t    m_r,
  output logic           m_rready,
  output logic           m_awvalid,
  output bus_pkg::aw_t   m_aw,
  input  logic           m_awready,
  output logic           m_wvalid,
  output bus_pkg::w_t    m_w,
  input  logic           m_wready,
  input  logic           m_bvalid,
  input  bus_pkg::resp_t m_bresp,
  output logic           m_bready
);

  axi_arbiter #(
    .CLINT_BASE(CLINT_BASE),
    .TIMER_DIV (TIMER_DIV)
  ) arb0 (
    .clock    (clock),
    .reset    (reset),
    .f_arvalid(f_arvalid),
    .f_araddr (f_araddr),
    .f_arready(f_arready),
    .f_rvalid (f_rvalid),
    .f_r      (f_r),
    .f_rready (f_rready),
    .d_arvalid(d_arvalid),
    .d_ar     (d_ar),
    .d_arready(d_arready),
    .d_rvalid (d_rvalid),
    .d_r      (d_r),
    .d_rready (d_rready),
    .d_awvalid(d_awvalid),
    .d_aw     (d_aw),
    .d_awready(d_awready),
    .d_wvalid (d_wvalid),
    .d_w      (d_w),
    .d_wready (d_wready),
    .d_bvalid (d_bvalid),
    .d_bresp  (d_bresp),
    .d_bready (d_bready),
    .m_arvalid(m_arvalid),
    .m_ar     (m_ar),
    .m_arready(m_arready),
    .m_rvalid (m_rvalid),
    .m_r      (m_r),
    .m_rready (m_rready),
    .m_awvalid(m_awvalid),
    .m_aw     (m_aw),
    .m_awready(m_awready),
    .m_wvalid (m_wvalid),
    .m_w      (m_w),
    .m_wready (m_wready),
    .m_bvalid (m_bvalid),
    .m_bresp  (m_bresp),
    .m_bready (m_bready)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_mem_subsystem \
  -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1
